//--- eaUnit_params.svh
`ifndef EAUNIT_PARAMS_SVH
`define EAUNIT_PARAMS_SVH

// Bus widths
`define DATA_W    8
`define ADDR_W    16
`define NUM_FLAGS 24

// Program counter and address register loads
`define PC_INC             0
`define LOAD_ABL           1
`define LOAD_ABH           2
// ADL / ADH bus sources
`define SET_ADL_TO_PCL     3
`define SET_ADH_TO_PCH     4
`define SET_ADL_TO_DATA    5
`define SET_ADH_TO_DATA    6
`define SET_ADL_TO_ALU     7
`define SET_ADH_LOW        8
`define SET_ADH_TO_SB      9
// DB / SB bus sources
`define SET_DB_TO_DATA     10
`define SET_DB_TO_SB       11
`define SET_SB_TO_X        12
`define SET_SB_TO_Y        13
`define SET_SB_TO_ALU      14
// Adder inputs and result
`define SET_INPUT_A_TO_SB  15
`define SET_INPUT_A_TO_LOW 16
`define SET_INPUT_B_TO_DB  17
`define SET_ALU_CARRY_HIGH 18
`define ALU_ADD            19
`define LOAD_ALU           20
`define CARRY_CAPTURE      21
// Result register
`define LOAD_EFF_ADDR      22
`define CLEAR_EFF_ADDR     23

`endif

//--- eaUnitPkg.sv
`include "eaUnit_params.svh"

package eaUnitPkg;

    typedef logic [`DATA_W-1:0]    dataByte_t;
    typedef logic [`ADDR_W-1:0]    addr_t;
    typedef logic [`NUM_FLAGS-1:0] ctrlFlags_t;

    // Addressing micro-steps
    typedef enum logic [1:0] {
        A0,
        A1,
        A2,
        A3
    } addrStep_t;

    typedef enum logic [3:0] {
        IMM,
        ZPG,
        ZPG_X,
        ZPG_Y,
        ABS,
        ABS_X,
        ABS_Y,
        IND_X,
        IND_Y,
        BAD
    } addrMode_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FINISH
    } seqState_t;

endpackage

//--- addrModeDecode.sv
`timescale 1ns/1ps

module addrModeDecode
    import eaUnitPkg::*;
(
    input  dataByte_t  opCode,
    output addrMode_t  mode,
    output logic [2:0] stepCount
);

    // Opcode to addressing mode
    always_comb begin
        mode = BAD;
        if (opCode[1:0] == 2'b01) begin
            // Group one opcodes carry the mode in bits 4:2
            case (opCode[4:2])
                3'b000: mode = IND_X;
                3'b001: mode = ZPG;
                3'b010: mode = IMM;
                3'b011: mode = ABS;
                3'b100: mode = IND_Y;
                3'b101: mode = ZPG_X;
                3'b110: mode = ABS_Y;
                default: mode = ABS_X;
            endcase
        end else if ((opCode == 8'h96) || (opCode == 8'hB6)) begin
            mode = ZPG_Y;
        end else if (opCode == 8'hBE) begin
            mode = ABS_Y;
        end
    end

    // Micro-steps needed per mode
    always_comb begin
        case (mode)
            ZPG: stepCount = 3'd1;
            ZPG_X, ZPG_Y, ABS: stepCount = 3'd2;
            ABS_X, ABS_Y: stepCount = 3'd3;
            IND_X, IND_Y: stepCount = 3'd4;
            default: stepCount = 3'd0;  // immediate or unsupported
        endcase
    end

endmodule

//--- addrModeFlags.sv
`timescale 1ns/1ps
`include "eaUnit_params.svh"

module addrModeFlags
    import eaUnitPkg::*;
(
    input  addrStep_t  step,
    input  addrMode_t  mode,
    input  logic       active,
    input  logic       carryToHigh,
    output ctrlFlags_t flags
);

    // X or Y for the shared indexed arms
    logic useX;

    assign useX = (mode == ZPG_X) || (mode == ABS_X);

    //////////////////////////////////////////////////////////////////////
    // Recurring flag groups
    //////////////////////////////////////////////////////////////////////

    // Data byte plus an index register into the adder
    function automatic ctrlFlags_t dataPlusIndex(input logic fromX);
        ctrlFlags_t f;
        f = '0;
        f[`SET_DB_TO_DATA] = 1'b1;
        f[`SET_INPUT_B_TO_DB] = 1'b1;
        f[`SET_SB_TO_X] = fromX;
        f[`SET_SB_TO_Y] = !fromX;
        f[`SET_INPUT_A_TO_SB] = 1'b1;
        f[`ALU_ADD] = 1'b1;
        f[`LOAD_ALU] = 1'b1;
        return f;
    endfunction

    // Data byte plus zero and a carry into the adder
    function automatic ctrlFlags_t dataPlusCarry(input logic carry);
        ctrlFlags_t f;
        f = '0;
        f[`SET_DB_TO_DATA] = 1'b1;
        f[`SET_INPUT_B_TO_DB] = 1'b1;
        f[`SET_INPUT_A_TO_LOW] = 1'b1;
        f[`SET_ALU_CARRY_HIGH] = carry;
        f[`ALU_ADD] = 1'b1;
        f[`LOAD_ALU] = 1'b1;
        return f;
    endfunction

    // Address bus to page zero, low byte from data or adder
    function automatic ctrlFlags_t zeroPage(input logic fromData);
        ctrlFlags_t f;
        f = '0;
        f[`SET_ADH_LOW] = 1'b1;
        f[`SET_ADL_TO_DATA] = fromData;
        f[`SET_ADL_TO_ALU] = !fromData;
        f[`LOAD_ABH] = 1'b1;
        f[`LOAD_ABL] = 1'b1;
        return f;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Per-mode step table
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        flags = '0;
        if (active) begin
            case (mode)
                IMM: begin
                    // Operand address is already on the bus
                    flags[`LOAD_EFF_ADDR] = 1'b1;
                end
                ZPG: begin
                    flags = zeroPage(1'b1);
                    flags[`LOAD_EFF_ADDR] = 1'b1;
                end
                ZPG_X, ZPG_Y: begin
                    if (step == A0) begin
                        flags = dataPlusIndex(useX);
                    end else begin
                        // Sum wraps inside page zero
                        flags = zeroPage(1'b0);
                        flags[`LOAD_EFF_ADDR] = 1'b1;
                    end
                end
                ABS: begin
                    if (step == A0) begin
                        // Park b0 in the adder, point at b1
                        flags = dataPlusCarry(1'b0);
                        flags[`PC_INC] = 1'b1;
                        flags[`SET_ADL_TO_PCL] = 1'b1;
                        flags[`SET_ADH_TO_PCH] = 1'b1;
                        flags[`LOAD_ABL] = 1'b1;
                        flags[`LOAD_ABH] = 1'b1;
                    end else begin
                        flags[`SET_ADL_TO_ALU] = 1'b1;
                        flags[`SET_ADH_TO_DATA] = 1'b1;
                        flags[`LOAD_ABL] = 1'b1;
                        flags[`LOAD_ABH] = 1'b1;
                        flags[`LOAD_EFF_ADDR] = 1'b1;
                    end
                end
                ABS_X, ABS_Y: begin
                    if (step == A0) begin
                        // Low byte index add, keep its carry
                        flags = dataPlusIndex(useX);
                        flags[`CARRY_CAPTURE] = 1'b1;
                        flags[`PC_INC] = 1'b1;
                        flags[`SET_ADL_TO_PCL] = 1'b1;
                        flags[`SET_ADH_TO_PCH] = 1'b1;
                        flags[`LOAD_ABL] = 1'b1;
                        flags[`LOAD_ABH] = 1'b1;
                    end else if (step == A1) begin
                        // High byte plus page-cross carry
                        flags = dataPlusCarry(carryToHigh);
                        flags[`SET_ADL_TO_ALU] = 1'b1;
                        flags[`LOAD_ABL] = 1'b1;
                    end else begin
                        flags[`SET_SB_TO_ALU] = 1'b1;
                        flags[`SET_ADH_TO_SB] = 1'b1;
                        flags[`LOAD_ABH] = 1'b1;
                        flags[`LOAD_EFF_ADDR] = 1'b1;
                    end
                end
                IND_X: begin
                    if (step == A0) begin
                        flags = dataPlusIndex(1'b1);
                    end else if (step == A1) begin
                        // Read pointer low, bump pointer through the adder
                        flags = zeroPage(1'b0);
                        flags[`SET_SB_TO_ALU] = 1'b1;
                        flags[`SET_DB_TO_SB] = 1'b1;
                        flags[`SET_INPUT_B_TO_DB] = 1'b1;
                        flags[`SET_INPUT_A_TO_LOW] = 1'b1;
                        flags[`SET_ALU_CARRY_HIGH] = 1'b1;
                        flags[`ALU_ADD] = 1'b1;
                        flags[`LOAD_ALU] = 1'b1;
                    end else if (step == A2) begin
                        // Pointer high address, stash target low
                        flags = zeroPage(1'b0) | dataPlusCarry(1'b0);
                    end else begin
                        flags[`SET_ADH_TO_DATA] = 1'b1;
                        flags[`SET_ADL_TO_ALU] = 1'b1;
                        flags[`LOAD_ABH] = 1'b1;
                        flags[`LOAD_ABL] = 1'b1;
                        flags[`LOAD_EFF_ADDR] = 1'b1;
                    end
                end
                IND_Y: begin
                    if (step == A0) begin
                        // Address 00:b0 and b0+1 in the adder
                        flags = zeroPage(1'b1) | dataPlusCarry(1'b1);
                    end else if (step == A1) begin
                        flags = zeroPage(1'b0) | dataPlusIndex(1'b0);
                        flags[`CARRY_CAPTURE] = 1'b1;
                    end else if (step == A2) begin
                        flags = dataPlusCarry(carryToHigh);
                        flags[`SET_ADL_TO_ALU] = 1'b1;
                        flags[`LOAD_ABL] = 1'b1;
                    end else begin
                        flags[`SET_SB_TO_ALU] = 1'b1;
                        flags[`SET_ADH_TO_SB] = 1'b1;
                        flags[`LOAD_ABH] = 1'b1;
                        flags[`LOAD_EFF_ADDR] = 1'b1;
                    end
                end
                default: begin
                    // Unsupported opcode reports address zero
                    flags[`CLEAR_EFF_ADDR] = 1'b1;
                end
            endcase
        end
    end

endmodule

//--- addrSequencer.sv
`timescale 1ns/1ps

module addrSequencer
    import eaUnitPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  addrMode_t  mode,
    input  logic [2:0] stepCount,
    input  logic       aluCarry,
    input  logic       carryCapture,
    output addrStep_t  step,
    output addrMode_t  latchedMode,
    output logic       active,
    output logic       carryToHigh,
    output logic       loadStart,
    output logic       busy,
    output logic       done,
    output logic       badMode
);

    seqState_t  state;
    logic [2:0] stepTotal;
    logic       lastStep;

    assign loadStart = start && (state == IDLE);
    assign busy = (state != IDLE);
    assign lastStep = (({1'b0, step} + 3'd1) == stepTotal);

    // Zero-step modes get one flag cycle in FINISH to settle the result
    assign active = (state == RUN) || ((state == FINISH) && (stepTotal == 3'd0));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            step <= A0;
            stepTotal <= '0;
            latchedMode <= IMM;
            carryToHigh <= 1'b0;
            done <= 1'b0;
            badMode <= 1'b0;
        end else begin
            done <= (state == FINISH);

            // Low byte carry held for the next step
            if (carryCapture) begin
                carryToHigh <= aluCarry;
            end

            case (state)
                IDLE: begin
                    if (start) begin
                        step <= A0;
                        stepTotal <= stepCount;
                        latchedMode <= mode;
                        badMode <= (mode == BAD);
                        carryToHigh <= 1'b0;
                        state <= (stepCount == 3'd0) ? FINISH : RUN;
                    end
                end
                RUN: begin
                    if (lastStep) begin
                        state <= FINISH;
                    end else begin
                        step <= addrStep_t'(step + 2'd1);
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- addrDatapath.sv
`timescale 1ns/1ps
`include "eaUnit_params.svh"

module addrDatapath
    import eaUnitPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       loadStart,
    input  addr_t      operandAddr,
    input  dataByte_t  xReg,
    input  dataByte_t  yReg,
    input  dataByte_t  memRdata,
    input  ctrlFlags_t flags,
    output addr_t      memAddr,
    output addr_t      effAddr,
    output logic       aluCarry
);

    addr_t            pc;
    dataByte_t        abl;
    dataByte_t        abh;
    dataByte_t        aluReg;
    dataByte_t        adlBus;
    dataByte_t        adhBus;
    dataByte_t        dbBus;
    dataByte_t        sbBus;
    dataByte_t        aluA;
    dataByte_t        aluB;
    dataByte_t        aluOut;
    logic [`DATA_W:0] aluSum;
    addr_t            abNext;

    //////////////////////////////////////////////////////////////////////
    // Internal buses
    //////////////////////////////////////////////////////////////////////

    // Unselected buses read as zero, which also serves as page zero
    always_comb begin
        sbBus = '0;
        if (flags[`SET_SB_TO_X]) begin
            sbBus = xReg;
        end else if (flags[`SET_SB_TO_Y]) begin
            sbBus = yReg;
        end else if (flags[`SET_SB_TO_ALU]) begin
            sbBus = aluReg;
        end

        dbBus = '0;
        if (flags[`SET_DB_TO_DATA]) begin
            dbBus = memRdata;
        end else if (flags[`SET_DB_TO_SB]) begin
            dbBus = sbBus;
        end

        adlBus = '0;
        if (flags[`SET_ADL_TO_PCL]) begin
            adlBus = pc[`DATA_W-1:0];
        end else if (flags[`SET_ADL_TO_DATA]) begin
            adlBus = memRdata;
        end else if (flags[`SET_ADL_TO_ALU]) begin
            adlBus = aluReg;
        end

        adhBus = '0;
        if (flags[`SET_ADH_TO_PCH]) begin
            adhBus = pc[`ADDR_W-1:`DATA_W];
        end else if (flags[`SET_ADH_TO_DATA]) begin
            adhBus = memRdata;
        end else if (flags[`SET_ADH_TO_SB]) begin
            adhBus = sbBus;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Adder
    //////////////////////////////////////////////////////////////////////

    assign aluA = flags[`SET_INPUT_A_TO_SB] ? sbBus : '0;
    assign aluB = flags[`SET_INPUT_B_TO_DB] ? dbBus : '0;
    assign aluSum = {1'b0, aluA} + {1'b0, aluB} + {{`DATA_W{1'b0}}, flags[`SET_ALU_CARRY_HIGH]};
    assign aluOut = flags[`ALU_ADD] ? aluSum[`DATA_W-1:0] : aluB;
    assign aluCarry = flags[`ALU_ADD] && aluSum[`DATA_W];

    always_ff @(posedge clk) begin
        if (flags[`LOAD_ALU]) begin
            aluReg <= aluOut;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // PC and address registers
    //////////////////////////////////////////////////////////////////////

    // Value the address register takes at the coming edge
    assign abNext = {flags[`LOAD_ABH] ? adhBus : abh, flags[`LOAD_ABL] ? adlBus : abl};
    assign memAddr = {abh, abl};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            abl <= '0;
            abh <= '0;
            effAddr <= '0;
        end else if (loadStart) begin
            pc <= operandAddr + 1'b1;
            abh <= operandAddr[`ADDR_W-1:`DATA_W];
            abl <= operandAddr[`DATA_W-1:0];
        end else begin
            if (flags[`PC_INC]) begin
                pc <= pc + 1'b1;
            end
            abh <= abNext[`ADDR_W-1:`DATA_W];
            abl <= abNext[`DATA_W-1:0];
            // Final step copies the new address out
            if (flags[`LOAD_EFF_ADDR]) begin
                effAddr <= abNext;
            end else if (flags[`CLEAR_EFF_ADDR]) begin
                effAddr <= '0;
            end
        end
    end

endmodule

//--- eaUnit.sv
`timescale 1ns/1ps
`include "eaUnit_params.svh"

module eaUnit
    import eaUnitPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  dataByte_t opCode,
    input  addr_t     operandAddr,
    input  dataByte_t xReg,
    input  dataByte_t yReg,
    input  dataByte_t memRdata,
    output addr_t     memAddr,
    output logic      busy,
    output logic      done,
    output addr_t     effAddr,
    output logic      badMode
);

    addrMode_t  mode;
    logic [2:0] stepCount;
    addrStep_t  step;
    addrMode_t  latchedMode;
    logic       active;
    logic       carryToHigh;
    logic       loadStart;
    logic       aluCarry;
    ctrlFlags_t flags;

    addrModeDecode u_decode (
        .opCode    (opCode),
        .mode      (mode),
        .stepCount (stepCount)
    );

    // Sequencer watches only the carry capture line
    addrSequencer u_sequencer (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .mode         (mode),
        .stepCount    (stepCount),
        .aluCarry     (aluCarry),
        .carryCapture (flags[`CARRY_CAPTURE]),
        .step         (step),
        .latchedMode  (latchedMode),
        .active       (active),
        .carryToHigh  (carryToHigh),
        .loadStart    (loadStart),
        .busy         (busy),
        .done         (done),
        .badMode      (badMode)
    );

    addrModeFlags u_flagGen (
        .step        (step),
        .mode        (latchedMode),
        .active      (active),
        .carryToHigh (carryToHigh),
        .flags       (flags)
    );

    addrDatapath u_datapath (
        .clk         (clk),
        .rst         (rst),
        .loadStart   (loadStart),
        .operandAddr (operandAddr),
        .xReg        (xReg),
        .yReg        (yReg),
        .memRdata    (memRdata),
        .flags       (flags),
        .memAddr     (memAddr),
        .effAddr     (effAddr),
        .aluCarry    (aluCarry)
    );

endmodule

//--- eaUnit_chk.sv
`timescale 1ns/1ps

module eaUnitChk
    import eaUnitPkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       done,
    input logic       busy,
    input logic       active,
    input ctrlFlags_t flags,
    input seqState_t  seqState
);

    int failCount;

    initial begin
        failCount = 0;
    end

    // Completion is a single-cycle pulse
    donePulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            failCount++;
            $error("done stayed high for more than one cycle");
        end

    // Sequencer is back in idle when done shows
    idleAfterDone: assert property (@(posedge clk) disable iff (rst) done |-> !busy)
        else begin
            failCount++;
            $error("busy still high during done");
        end

    // No micro-step runs while idle
    quietWhenIdle: assert property (@(posedge clk) disable iff (rst)
        (seqState == IDLE) |-> (!active && (flags == '0)))
        else begin
            failCount++;
            $error("control flags active while the sequencer is idle");
        end

endmodule

bind eaUnit eaUnitChk u_chk (
    .clk      (clk),
    .rst      (rst),
    .done     (done),
    .busy     (busy),
    .active   (active),
    .flags    (flags),
    .seqState (u_sequencer.state)
);

//--- eaUnit_tb.sv
`timescale 1ns/1ps

module eaUnit_tb
    import eaUnitPkg::*;
();

    localparam int maxWait = 20;

    logic       clk;
    logic       rst;
    logic       start;
    dataByte_t  opCode;
    addr_t      operandAddr;
    dataByte_t  xReg;
    dataByte_t  yReg;
    dataByte_t  memRdata;
    addr_t      memAddr;
    logic       busy;
    logic       done;
    addr_t      effAddr;
    logic       badMode;

    logic [7:0]  mem [0:65535];
    logic [31:0] seed;
    logic [16:0] expQueue [$];

    eaUnit u_dut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .opCode      (opCode),
        .operandAddr (operandAddr),
        .xReg        (xReg),
        .yReg        (yReg),
        .memRdata    (memRdata),
        .memAddr     (memAddr),
        .busy        (busy),
        .done        (done),
        .effAddr     (effAddr),
        .badMode     (badMode)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Byte port, data valid well before the next rising edge
    always @(negedge clk) begin
        memRdata <= mem[memAddr];
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic addrMode_t refMode(input logic [7:0] op);
        addrMode_t m;
        m = BAD;
        if (op[1:0] == 2'b01) begin
            case (op[4:2])
                3'd0: m = IND_X;
                3'd1: m = ZPG;
                3'd2: m = IMM;
                3'd3: m = ABS;
                3'd4: m = IND_Y;
                3'd5: m = ZPG_X;
                3'd6: m = ABS_Y;
                default: m = ABS_X;
            endcase
        end else if (op == 8'h96 || op == 8'hB6) begin
            m = ZPG_Y;
        end else if (op == 8'hBE) begin
            m = ABS_Y;
        end
        return m;
    endfunction

    function automatic int stepsFor(input addrMode_t m);
        case (m)
            ZPG: return 1;
            ZPG_X, ZPG_Y, ABS: return 2;
            ABS_X, ABS_Y: return 3;
            IND_X, IND_Y: return 4;
            default: return 0;
        endcase
    endfunction

    // Bit 16 is badMode, the rest the effective address
    function automatic logic [16:0] refEffAddr(input logic [7:0] op, input addr_t oa,
                                               input logic [7:0] x, input logic [7:0] y);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] p;
        logic [7:0] pNext;
        addr_t      ea;
        logic       bad;
        b0 = mem[oa];
        b1 = mem[oa + 16'd1];
        ea = '0;
        bad = 1'b0;
        case (refMode(op))
            IMM: ea = oa;
            ZPG: ea = {8'h00, b0};
            ZPG_X: begin
                p = b0 + x;
                ea = {8'h00, p};
            end
            ZPG_Y: begin
                p = b0 + y;
                ea = {8'h00, p};
            end
            ABS: ea = {b1, b0};
            ABS_X: ea = {b1, b0} + {8'h00, x};
            ABS_Y: ea = {b1, b0} + {8'h00, y};
            IND_X: begin
                p = b0 + x;
                pNext = p + 8'd1;
                ea = {mem[{8'h00, pNext}], mem[{8'h00, p}]};
            end
            IND_Y: begin
                pNext = b0 + 8'd1;
                ea = {mem[{8'h00, pNext}], mem[{8'h00, b0}]} + {8'h00, y};
            end
            default: bad = 1'b1;
        endcase
        return {bad, ea};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Results come out in request order
    always @(negedge clk) begin
        logic [16:0] exp;
        if (!rst && done) begin
            if (expQueue.size() == 0) begin
                $display("A done pulse arrived with no request outstanding");
                $display("CHECKS FAILED");
                $fatal(1, "unexpected done");
            end else begin
                exp = expQueue.pop_front();
                checkValue("effAddr", 32'(effAddr), 32'(exp[15:0]));
                checkValue("badMode", 32'(badMode), 32'(exp[16]));
            end
        end
    end

    task automatic waitForDone(output int cycles);
        cycles = 1;
        while (!done) begin
            if (cycles >= maxWait) begin
                $display("Timeout while waiting for the done pulse");
                $display("CHECKS FAILED");
                $fatal(1, "no done within %0d cycles", maxWait);
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic issueStart(input logic [7:0] op, input addr_t oa,
                              input logic [7:0] x, input logic [7:0] y);
        @(negedge clk);
        opCode = op;
        operandAddr = oa;
        xReg = x;
        yReg = y;
        start = 1'b1;
        expQueue.push_back(refEffAddr(op, oa, x, y));
        @(negedge clk);
        start = 1'b0;
        checkValue("busy", 32'(busy), 32'd1);
    endtask

    // Latency counted from the accepting edge
    task automatic runCalc(input logic [7:0] op, input addr_t oa,
                           input logic [7:0] x, input logic [7:0] y);
        int cycles;
        issueStart(op, oa, x, y);
        waitForDone(cycles);
        checkValue("doneLatency", 32'(cycles - 1), 32'(stepsFor(refMode(op)) + 1));
    endtask

    // Reference cross-checked against a hand-worked address
    task automatic runKnown(input logic [7:0] op, input addr_t oa, input logic [7:0] x,
                            input logic [7:0] y, input logic [16:0] known);
        checkValue("refEffAddr", 32'(refEffAddr(op, oa, x, y)), 32'(known));
        runCalc(op, oa, x, y);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [7:0] op;
        addr_t      oa;
        logic [7:0] x;
        logic [7:0] y;
        int         cycles;
        rst = 1'b1;
        start = 1'b0;
        opCode = '0;
        operandAddr = '0;
        xReg = '0;
        yReg = '0;
        memRdata = '0;
        seed = 32'hf9a0c500;
        for (int i = 0; i < 65536; i++) begin
            seed = lcg(seed);
            mem[i] = seed[23:16];
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checkValue("done", 32'(done), 32'd0);
        checkValue("busy", 32'(busy), 32'd0);
        checkValue("badMode", 32'(badMode), 32'd0);
        checkValue("memAddr", 32'(memAddr), 32'd0);

        // One case per mode
        mem[16'h0200] = 8'h42;
        mem[16'h0210] = 8'h30;
        mem[16'h0220] = 8'h80;
        mem[16'h0230] = 8'h34;
        mem[16'h0231] = 8'h12;
        mem[16'h0240] = 8'h10;
        mem[16'h0241] = 8'h20;
        mem[16'h0250] = 8'h00;
        mem[16'h0251] = 8'h30;
        mem[16'h0260] = 8'h40;
        mem[16'h0044] = 8'h78;
        mem[16'h0045] = 8'h56;
        mem[16'h0270] = 8'h50;
        mem[16'h0050] = 8'h00;
        mem[16'h0051] = 8'h60;
        runKnown(8'hA9, 16'h1234, 8'h00, 8'h00, 17'h01234);
        runKnown(8'hA5, 16'h0200, 8'h00, 8'h00, 17'h00042);
        runKnown(8'hB5, 16'h0210, 8'h05, 8'h00, 17'h00035);
        runKnown(8'hB6, 16'h0220, 8'h00, 8'h10, 17'h00090);
        runKnown(8'hAD, 16'h0230, 8'h00, 8'h00, 17'h01234);
        runKnown(8'hBD, 16'h0240, 8'h03, 8'h00, 17'h02013);
        runKnown(8'hB9, 16'h0250, 8'h00, 8'h44, 17'h03044);
        runKnown(8'hBE, 16'h0250, 8'h00, 8'h45, 17'h03045);
        runKnown(8'hA1, 16'h0260, 8'h04, 8'h00, 17'h05678);
        runKnown(8'hB1, 16'h0270, 8'h00, 8'h22, 17'h06022);

        // Page crossing and zero-page wrap
        mem[16'h0280] = 8'hF0;
        mem[16'h0281] = 8'h12;
        mem[16'h0290] = 8'h60;
        mem[16'h0060] = 8'hF8;
        mem[16'h0061] = 8'h3F;
        mem[16'h02A0] = 8'hF0;
        mem[16'h02B0] = 8'hFB;
        mem[16'h00FF] = 8'hCD;
        mem[16'h0000] = 8'hAB;
        mem[16'h02C0] = 8'hFF;
        runKnown(8'hDD, 16'h0280, 8'h20, 8'h00, 17'h01310);
        runKnown(8'h51, 16'h0290, 8'h00, 8'h10, 17'h04008);
        runKnown(8'hB5, 16'h02A0, 8'h20, 8'h00, 17'h00010);
        runKnown(8'h01, 16'h02B0, 8'h04, 8'h00, 17'h0ABCD);
        runKnown(8'h71, 16'h02C0, 8'h00, 8'h40, 17'h0AC0D);

        // Unsupported opcodes
        runKnown(8'h00, 16'h0300, 8'h00, 8'h00, 17'h10000);
        runKnown(8'h02, 16'h0301, 8'h11, 8'h22, 17'h10000);

        // Second start lands while the first is running
        issueStart(8'hDD, 16'h0280, 8'h20, 8'h00);
        @(negedge clk);
        opCode = 8'hA5;
        operandAddr = 16'h0200;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        waitForDone(cycles);
        // Window for a stray second done
        repeat (6) @(negedge clk);

        // Random operands, group one opcodes favoured
        for (int i = 0; i < 300; i++) begin
            seed = lcg(seed);
            op = seed[31:24];
            if (seed[15]) begin
                op[1:0] = 2'b01;
            end
            oa = seed[23:8];
            seed = lcg(seed);
            x = seed[31:24];
            y = seed[23:16];
            runCalc(op, oa, x, y);
        end
        repeat (4) @(negedge clk);

        if (u_dut.u_chk.failCount == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "bound assertions failed %0d times", u_dut.u_chk.failCount);
        end
    end

endmodule

//--- verilog.f
+incdir+.
eaUnitPkg.sv
addrModeDecode.sv
addrModeFlags.sv
addrSequencer.sv
addrDatapath.sv
eaUnit.sv
eaUnit_chk.sv
eaUnit_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the eaUnit testbench with Verilator, then scan the log
rm -f sim.log &&
{ verilator --binary --timing --assert -f verilog.f --top-module eaUnit_tb \
    -Mdir obj_dir -o eaUnit_sim && ./obj_dir/eaUnit_sim; } > sim.log 2>&1
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" ||
    { echo "simulation failed, see sim.log"; exit 1; }
